/* verilog/gat_pkg.sv */
package gat_pkg;

  // feature word layout.
  localparam int FEAT_ELEMS = 4;
  localparam int ELEM_W     = 8;
  localparam int FEAT_W     = FEAT_ELEMS * ELEM_W;
  localparam int SEL_W      = $clog2(FEAT_ELEMS);

  // score and attention weight widths.
  localparam int WH_W  = 18;
  localparam int E_W   = 16;
  localparam int SUM_W = 20;

  // aggregation group size.
  localparam int GROUP_NODES = 4;

  // debugger probe points on the node index.
  localparam int PROBE_NODE_A = 2;
  localparam int PROBE_NODE_B = 5;

  // leaky relu slope is 1/8 for negative scores.
  localparam int LEAK_SHIFT = 3;

  // exponent approximation, e = 2^(clamp(r >> EXP_SHIFT) + EXP_BIAS).
  localparam int EXP_SHIFT = 4;
  localparam int EXP_MIN   = -8;
  localparam int EXP_MAX   = 7;
  localparam int EXP_BIAS  = 8;

  // debug counters and node index.
  localparam int CNT_W = 16;

endpackage

/* verilog/gat_dmvm.sv */
`timescale 1ns/1ps

module gat_dmvm (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             wgt_we_i,
  input  logic [gat_pkg::SEL_W-1:0]        wgt_addr_i,
  input  logic [gat_pkg::ELEM_W-1:0]       wgt_data_i,
  input  logic                             dmvm_vld_i,
  input  logic [gat_pkg::FEAT_W-1:0]       feat_i,
  output logic                             dmvm_rdy_o,
  output logic signed [gat_pkg::WH_W-1:0]  wh_o,
  output logic [gat_pkg::CNT_W-1:0]        node_idx_o
);

  logic signed [gat_pkg::ELEM_W-1:0]   wgt_q [gat_pkg::FEAT_ELEMS];
  logic [gat_pkg::FEAT_W-1:0]          feat_q;
  logic [gat_pkg::SEL_W-1:0]           step;
  logic                                busy;
  logic                                rdy_q;
  logic signed [gat_pkg::WH_W-1:0]     acc;
  logic [gat_pkg::CNT_W-1:0]           node_idx;
  logic signed [gat_pkg::ELEM_W-1:0]   mac_w;
  logic signed [gat_pkg::ELEM_W-1:0]   mac_x;
  logic signed [2*gat_pkg::ELEM_W-1:0] mac_prod;
  logic signed [gat_pkg::WH_W-1:0]     mac_ext;

  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_q[wgt_addr_i] <= wgt_data_i;
    end
  end

  // element 0 is taken straight from the incoming word on the strobe.
  // step wraps back to zero when idle, so it also picks weight 0 then.
  assign mac_x    = busy ? feat_q[step*gat_pkg::ELEM_W +: gat_pkg::ELEM_W]
                         : feat_i[gat_pkg::ELEM_W-1:0];
  assign mac_w    = wgt_q[step];
  assign mac_prod = mac_w * mac_x;
  assign mac_ext  = {{(gat_pkg::WH_W-2*gat_pkg::ELEM_W){mac_prod[2*gat_pkg::ELEM_W-1]}},
                     mac_prod};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      step     <= '0;
      rdy_q    <= 1'b0;
      node_idx <= '0;
    end else begin
      rdy_q <= 1'b0;
      if (dmvm_vld_i) begin
        busy <= 1'b1;
        step <= gat_pkg::SEL_W'(1);
      end else if (busy) begin
        step <= step + 1'b1;
        if (int'(step) == gat_pkg::FEAT_ELEMS - 1) begin
          busy  <= 1'b0;
          rdy_q <= 1'b1;
        end
      end
      // index moves on once the current score has been presented.
      if (rdy_q) begin
        node_idx <= node_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dmvm_vld_i) begin
      feat_q <= feat_i;
      acc    <= mac_ext;
    end else if (busy) begin
      acc <= acc + mac_ext;
    end
  end

  assign dmvm_rdy_o = rdy_q;
  assign wh_o       = acc;
  assign node_idx_o = node_idx;

  // nodes must be spaced so that one never lands on a running mac.
  assert property (@(posedge clk) disable iff (!rst_n) dmvm_vld_i |-> !busy);

endmodule

/* verilog/gat_softmax_exp.sv */
`timescale 1ns/1ps

module gat_softmax_exp (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            sm_vld_i,
  input  logic signed [gat_pkg::WH_W-1:0] wh_i,
  output logic                            sm_rdy_o,
  output logic [gat_pkg::E_W-1:0]         e_o
);

  logic signed [gat_pkg::WH_W-1:0] rect;
  logic signed [gat_pkg::WH_W-1:0] k_raw;
  int                              k_exp;
  logic [gat_pkg::E_W-1:0]         e_next;

  always_comb begin
    // leaky relu.
    rect  = wh_i[gat_pkg::WH_W-1] ? (wh_i >>> gat_pkg::LEAK_SHIFT) : wh_i;
    k_raw = rect >>> gat_pkg::EXP_SHIFT;
    if (k_raw < gat_pkg::EXP_MIN) begin
      k_exp = gat_pkg::EXP_MIN;
    end else if (k_raw > gat_pkg::EXP_MAX) begin
      k_exp = gat_pkg::EXP_MAX;
    end else begin
      k_exp = int'(k_raw);
    end
    e_next = {{(gat_pkg::E_W-1){1'b0}}, 1'b1} << (k_exp + gat_pkg::EXP_BIAS);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_rdy_o <= 1'b0;
    end else begin
      sm_rdy_o <= sm_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (sm_vld_i) begin
      e_o <= e_next;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) sm_rdy_o |-> $onehot(e_o));

endmodule

/* verilog/gat_aggr.sv */
`timescale 1ns/1ps

module gat_aggr (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      aggr_vld_i,
  input  logic [gat_pkg::E_W-1:0]   e_i,
  output logic                      aggr_rdy_o,
  output logic [gat_pkg::SUM_W-1:0] group_sum_o
);

  logic [gat_pkg::SUM_W-1:0]               acc;
  logic [gat_pkg::SUM_W-1:0]               acc_next;
  logic [$clog2(gat_pkg::GROUP_NODES):0]   grp_cnt;
  logic                                    grp_last;

  assign acc_next = acc + {{(gat_pkg::SUM_W-gat_pkg::E_W){1'b0}}, e_i};
  assign grp_last = (int'(grp_cnt) == gat_pkg::GROUP_NODES - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc        <= '0;
      grp_cnt    <= '0;
      aggr_rdy_o <= 1'b0;
    end else begin
      aggr_rdy_o <= 1'b0;
      if (aggr_vld_i) begin
        if (grp_last) begin
          // close the group and start the next one from zero.
          acc        <= '0;
          grp_cnt    <= '0;
          aggr_rdy_o <= 1'b1;
        end else begin
          acc     <= acc_next;
          grp_cnt <= grp_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aggr_vld_i && grp_last) begin
      group_sum_o <= acc_next;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    int'(grp_cnt) < gat_pkg::GROUP_NODES);

endmodule

/* verilog/gat_debugger.sv */
`timescale 1ns/1ps

module gat_debugger (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      dmvm_vld_i,
  input  logic                      dmvm_rdy_i,
  input  logic                      sm_vld_i,
  input  logic                      sm_rdy_i,
  input  logic                      aggr_vld_i,
  input  logic                      aggr_rdy_i,
  input  logic [gat_pkg::WH_W-1:0]  wh_i,
  input  logic [gat_pkg::CNT_W-1:0] node_idx_i,
  output logic [5:0]                debug_flags_o,
  output logic [gat_pkg::CNT_W-1:0] debug_count_o,
  output logic [gat_pkg::WH_W-1:0]  debug_cap_a_o,
  output logic [gat_pkg::WH_W-1:0]  debug_cap_b_o
);

  logic [5:0]                pulses;
  logic [5:0]                flags_q;
  logic [gat_pkg::CNT_W-1:0] sm_cnt;
  logic [gat_pkg::WH_W-1:0]  cap_a;
  logic [gat_pkg::WH_W-1:0]  cap_b;
  logic                      hit_a;
  logic                      hit_b;

  // pipeline order, first stage in the top bit.
  assign pulses = {dmvm_vld_i, dmvm_rdy_i, sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i};

  assign hit_a = dmvm_rdy_i && (node_idx_i == gat_pkg::PROBE_NODE_A);
  assign hit_b = dmvm_rdy_i && (node_idx_i == gat_pkg::PROBE_NODE_B);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      sm_cnt  <= '0;
      cap_a   <= '0;
      cap_b   <= '0;
    end else begin
      // sticky until reset.
      flags_q <= flags_q | pulses;
      if (sm_vld_i) begin
        sm_cnt <= sm_cnt + 1'b1;
      end
      if (hit_a) begin
        cap_a <= wh_i;
      end
      if (hit_b) begin
        cap_b <= wh_i;
      end
    end
  end

  assign debug_flags_o = flags_q;
  assign debug_count_o = sm_cnt;
  assign debug_cap_a_o = cap_a;
  assign debug_cap_b_o = cap_b;

endmodule

/* verilog/gat_top.sv */
`timescale 1ns/1ps

module gat_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wgt_we_i,
  input  logic [gat_pkg::SEL_W-1:0]  wgt_addr_i,
  input  logic [gat_pkg::ELEM_W-1:0] wgt_data_i,
  input  logic                       node_vld_i,
  input  logic [gat_pkg::FEAT_W-1:0] node_feat_i,
  output logic                       e_vld_o,
  output logic [gat_pkg::E_W-1:0]    e_o,
  output logic                       group_vld_o,
  output logic [gat_pkg::SUM_W-1:0]  group_sum_o,
  output logic [5:0]                 debug_flags_o,
  output logic [gat_pkg::CNT_W-1:0]  debug_count_o,
  output logic [gat_pkg::WH_W-1:0]   debug_cap_a_o,
  output logic [gat_pkg::WH_W-1:0]   debug_cap_b_o
);

  logic                      dmvm_rdy;
  logic [gat_pkg::WH_W-1:0]  wh;
  logic [gat_pkg::CNT_W-1:0] node_idx;
  logic                      sm_rdy;
  logic                      aggr_rdy;

  gat_dmvm u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i),
    .dmvm_vld_i (node_vld_i),
    .feat_i     (node_feat_i),
    .dmvm_rdy_o (dmvm_rdy),
    .wh_o       (wh),
    .node_idx_o (node_idx)
  );

  gat_softmax_exp u_softmax_exp (
    .clk      (clk),
    .rst_n    (rst_n),
    .sm_vld_i (dmvm_rdy),
    .wh_i     (wh),
    .sm_rdy_o (sm_rdy),
    .e_o      (e_o)
  );

  gat_aggr u_aggr (
    .clk         (clk),
    .rst_n       (rst_n),
    .aggr_vld_i  (sm_rdy),
    .e_i         (e_o),
    .aggr_rdy_o  (aggr_rdy),
    .group_sum_o (group_sum_o)
  );

  // done of each stage starts the next one.
  gat_debugger u_debugger (
    .clk           (clk),
    .rst_n         (rst_n),
    .dmvm_vld_i    (node_vld_i),
    .dmvm_rdy_i    (dmvm_rdy),
    .sm_vld_i      (dmvm_rdy),
    .sm_rdy_i      (sm_rdy),
    .aggr_vld_i    (sm_rdy),
    .aggr_rdy_i    (aggr_rdy),
    .wh_i          (wh),
    .node_idx_i    (node_idx),
    .debug_flags_o (debug_flags_o),
    .debug_count_o (debug_count_o),
    .debug_cap_a_o (debug_cap_a_o),
    .debug_cap_b_o (debug_cap_b_o)
  );

  assign e_vld_o     = sm_rdy;
  assign group_vld_o = aggr_rdy;

endmodule

/* verif/gat_checker.sv */
`timescale 1ns/1ps

module gat_checker #(
  parameter int MAX_NODES = 32
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      node_vld_i,
  input  logic                      e_vld_i,
  input  logic [gat_pkg::E_W-1:0]   e_i,
  input  logic                      group_vld_i,
  input  logic [gat_pkg::SUM_W-1:0] group_sum_i,
  input  logic [5:0]                debug_flags_i,
  input  logic [gat_pkg::CNT_W-1:0] debug_count_i,
  input  logic [gat_pkg::WH_W-1:0]  debug_cap_a_i,
  input  logic [gat_pkg::WH_W-1:0]  debug_cap_b_i,
  input  logic [gat_pkg::E_W-1:0]   exp_e_i [MAX_NODES],
  input  logic [gat_pkg::WH_W-1:0]  exp_wh_i [MAX_NODES],
  input  int                        node_count_i,
  input  logic                      final_check_i,
  output int                        err_value_o,
  output int                        err_timing_o,
  output int                        err_state_o,
  output int                        e_seen_o,
  output int                        group_seen_o
);

  int cyc        = 0;
  int nodes_seen = 0;
  int e_seen     = 0;
  int grp_seen   = 0;
  int grp_acc    = 0;
  int err_value  = 0;
  int err_timing = 0;
  int err_state  = 0;
  int strobe_q[$];
  int grp_cyc_q[$];
  int grp_sum_q[$];

  function automatic bit check_equal(input string test, input logic [31:0] expected,
                                     input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %0d actual %0d", test, expected, actual);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // everything the monitor shows must still be clear before the first node.
  task automatic expect_idle_state();
    if (!check_equal("idle debug_flags", 32'h0, 32'(debug_flags_i))) err_state++;
    if (!check_equal("idle debug_count", 32'h0, 32'(debug_count_i))) err_state++;
    if (!check_equal("idle debug_cap_a", 32'h0, 32'(debug_cap_a_i))) err_state++;
    if (!check_equal("idle debug_cap_b", 32'h0, 32'(debug_cap_b_i))) err_state++;
    if (!check_equal("idle e_vld", 32'h0, 32'(e_vld_i))) err_state++;
    if (!check_equal("idle group_vld", 32'h0, 32'(group_vld_i))) err_state++;
  endtask

  always @(posedge clk) begin
    int t;
    int exp_sum;
    if (rst_n) begin
      cyc = cyc + 1;
      if (e_vld_i) begin
        if (strobe_q.size() == 0) begin
          $display("e_vld_o pulsed at cycle %0d with no node in flight", cyc);
          err_timing++;
        end else begin
          t = strobe_q.pop_front();
          if (!check_equal($sformatf("e latency node %0d", e_seen), t + 5, cyc)) err_timing++;
          if (!check_equal($sformatf("exponent weight node %0d", e_seen),
                           32'(exp_e_i[e_seen]), 32'(e_i))) err_value++;
          grp_acc = grp_acc + int'(exp_e_i[e_seen]);
          // a group closes on its last node, one cycle after that node's e.
          if ((e_seen + 1) % gat_pkg::GROUP_NODES == 0) begin
            grp_sum_q.push_back(grp_acc);
            grp_cyc_q.push_back(t + 6);
            grp_acc = 0;
          end
          e_seen++;
        end
      end
      if (group_vld_i) begin
        if (grp_sum_q.size() == 0) begin
          $display("group_vld_o pulsed at cycle %0d before any group was complete", cyc);
          err_timing++;
        end else begin
          exp_sum = grp_sum_q.pop_front();
          t = grp_cyc_q.pop_front();
          if (!check_equal($sformatf("group sum %0d", grp_seen), exp_sum,
                           32'(group_sum_i))) err_value++;
          if (!check_equal($sformatf("group latency %0d", grp_seen), t, cyc)) err_timing++;
          grp_seen++;
        end
      end
      if (node_vld_i) begin
        if (nodes_seen == 0) begin
          expect_idle_state();
        end
        strobe_q.push_back(cyc);
        nodes_seen++;
      end
      if (final_check_i) begin
        if (!check_equal("final debug_flags", 32'h3f, 32'(debug_flags_i))) err_state++;
        if (!check_equal("final debug_count", node_count_i, 32'(debug_count_i))) err_state++;
        if (!check_equal("final debug_cap_a", 32'(exp_wh_i[gat_pkg::PROBE_NODE_A]),
                         32'(debug_cap_a_i))) err_state++;
        if (!check_equal("final debug_cap_b", 32'(exp_wh_i[gat_pkg::PROBE_NODE_B]),
                         32'(debug_cap_b_i))) err_state++;
        if (strobe_q.size() != 0 || grp_sum_q.size() != 0) begin
          $display("nodes or groups were still outstanding at the end of the run");
          err_timing++;
        end
      end
    end
  end

  assign err_value_o  = err_value;
  assign err_timing_o = err_timing;
  assign err_state_o  = err_state;
  assign e_seen_o     = e_seen;
  assign group_seen_o = grp_seen;

endmodule

/* verif/tb_gat.sv */
`timescale 1ns/1ps

module tb_gat;

  localparam int MAX_NODES = 32;
  localparam int MEM_WORDS = 128;
  localparam int NODE_BASE = 2 * gat_pkg::FEAT_ELEMS + 1;

  logic                       clk;
  logic                       rst_n;
  logic                       wgt_we;
  logic [gat_pkg::SEL_W-1:0]  wgt_addr;
  logic [gat_pkg::ELEM_W-1:0] wgt_data;
  logic                       node_vld;
  logic [gat_pkg::FEAT_W-1:0] node_feat;
  logic                       final_check;
  logic                       e_vld;
  logic [gat_pkg::E_W-1:0]    e_val;
  logic                       group_vld;
  logic [gat_pkg::SUM_W-1:0]  group_sum;
  logic [5:0]                 debug_flags;
  logic [gat_pkg::CNT_W-1:0]  debug_count;
  logic [gat_pkg::WH_W-1:0]   debug_cap_a;
  logic [gat_pkg::WH_W-1:0]   debug_cap_b;

  logic [31:0]                stim_mem [MEM_WORDS];
  logic [gat_pkg::E_W-1:0]    exp_e [MAX_NODES];
  logic [gat_pkg::WH_W-1:0]   exp_wh [MAX_NODES];
  int                         node_count;
  bit                         loaded;
  int                         err_value;
  int                         err_timing;
  int                         err_state;
  int                         e_seen;
  int                         group_seen;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  gat_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .wgt_we_i      (wgt_we),
    .wgt_addr_i    (wgt_addr),
    .wgt_data_i    (wgt_data),
    .node_vld_i    (node_vld),
    .node_feat_i   (node_feat),
    .e_vld_o       (e_vld),
    .e_o           (e_val),
    .group_vld_o   (group_vld),
    .group_sum_o   (group_sum),
    .debug_flags_o (debug_flags),
    .debug_count_o (debug_count),
    .debug_cap_a_o (debug_cap_a),
    .debug_cap_b_o (debug_cap_b)
  );

  gat_checker #(.MAX_NODES(MAX_NODES)) checker0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .node_vld_i    (node_vld),
    .e_vld_i       (e_vld),
    .e_i           (e_val),
    .group_vld_i   (group_vld),
    .group_sum_i   (group_sum),
    .debug_flags_i (debug_flags),
    .debug_count_i (debug_count),
    .debug_cap_a_i (debug_cap_a),
    .debug_cap_b_i (debug_cap_b),
    .exp_e_i       (exp_e),
    .exp_wh_i      (exp_wh),
    .node_count_i  (node_count),
    .final_check_i (final_check),
    .err_value_o   (err_value),
    .err_timing_o  (err_timing),
    .err_state_o   (err_state),
    .e_seen_o      (e_seen),
    .group_seen_o  (group_seen)
  );

  task automatic load_weight(input logic [gat_pkg::SEL_W-1:0] addr,
                             input logic [gat_pkg::ELEM_W-1:0] data);
    @(negedge clk);
    wgt_we   = 1'b1;
    wgt_addr = addr;
    wgt_data = data;
  endtask

  // one strobe, then quiet until six cycles have passed.
  task automatic send_node(input logic [gat_pkg::FEAT_W-1:0] feat);
    @(negedge clk);
    node_vld  = 1'b1;
    node_feat = feat;
    @(negedge clk);
    node_vld = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  initial begin
    rst_n       = 1'b0;
    wgt_we      = 1'b0;
    wgt_addr    = '0;
    wgt_data    = '0;
    node_vld    = 1'b0;
    node_feat   = '0;
    final_check = 1'b0;
    $readmemh("verif/gat_stimulus.txt", stim_mem);
    node_count = int'(stim_mem[2 * gat_pkg::FEAT_ELEMS]);
    for (int i = 0; i < MAX_NODES; i++) begin
      if (i < node_count) begin
        exp_wh[i] = stim_mem[NODE_BASE + 3 * i + 1][gat_pkg::WH_W-1:0];
        exp_e[i]  = stim_mem[NODE_BASE + 3 * i + 2][gat_pkg::E_W-1:0];
      end else begin
        exp_wh[i] = '0;
        exp_e[i]  = '0;
      end
    end
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < gat_pkg::FEAT_ELEMS; i++) begin
      load_weight(stim_mem[2 * i][gat_pkg::SEL_W-1:0], stim_mem[2 * i + 1][gat_pkg::ELEM_W-1:0]);
    end
    @(negedge clk);
    wgt_we = 1'b0;
    for (int i = 0; i < node_count; i++) begin
      send_node(stim_mem[NODE_BASE + 3 * i]);
    end
    wait (e_seen == node_count && group_seen == node_count / gat_pkg::GROUP_NODES);
    @(negedge clk);
    final_check = 1'b1;
    @(negedge clk);
    final_check = 1'b0;
    $display("errors: value %0d, latency %0d, state %0d", err_value, err_timing, err_state);
    if (err_value + err_timing + err_state == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (node_count * 6 + 50) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", node_count * 6 + 50);
    $display("Something failed");
    $finish;
  end

endmodule

/* verif/gat_stimulus.txt */
// weights: address, signed byte value; then the node count
// nodes: feature word (element 0 in the low byte), expected wh (18-bit), expected e
0 01
1 02
2 FF
3 0A
8
0200050A 00028 0400
64006464 00514 8000
00320000 3FFCE 0080
00000000 00000 0100
807F8080 3F901 0001
05F90403 00044 1000
9C000000 3FC18 0001
00009C00 3FF38 0040

/* project.f */
verilog/gat_pkg.sv
verilog/gat_dmvm.sv
verilog/gat_softmax_exp.sv
verilog/gat_aggr.sv
verilog/gat_debugger.sv
verilog/gat_top.sv
verif/gat_checker.sv
verif/tb_gat.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gat -f project.f -o tb_gat

./obj_dir/tb_gat | tee sim.log

grep -q "Everything OK" sim.log
